// File: stream_sink.f
logic/sink_pkg.sv
logic/sink_addr_gen.sv
logic/sink_addr_fifo.sv
logic/stream_sink.sv
logic/scratch_mem.sv
logic/sink_subsystem.sv
verification/sink_checker.sv
verification/tb_sink_subsystem.sv

// File: verification/tb_sink_subsystem.sv
// Testbench for the streaming write engine.
// Clock and reset, LFSR-driven jobs, beats and read stalls,
// a memory model with read-back comparison, and the closing report.

`timescale 1ns/1ns

module tb_sink_subsystem;

  import sink_pkg::*;

  localparam int unsigned MEM_DEPTH  = 64;
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int          NUM_JOBS   = 20;
  localparam int          MAX_LEN    = 16;
  // Random jobs plus the initial clearing pass and its read-back.
  localparam int          TIMEOUT    = NUM_JOBS * (MAX_LEN * 4 + 100) + MEM_DEPTH * 6;

  logic        clk_i, rst_ni, start_i, ready_start_o, done_o;
  logic        valid_i, ready_o, rd_req_i;
  addr_t       base_i, stride_i, rd_addr_i;
  len_t        len_i;
  word_t       data_i, rd_data_o;
  strb_t       strb_i;
  word_t       model [MEM_DEPTH];  // Expected scratchpad contents.
  logic [31:0] lfsr;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  sink_subsystem #(
    .MEM_DEPTH  ( MEM_DEPTH  ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) uut (
    .clk_i, .rst_ni, .start_i, .base_i, .stride_i, .len_i, .ready_start_o, .done_o,
    .data_i, .strb_i, .valid_i, .ready_o, .rd_req_i, .rd_addr_i, .rd_data_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT);
      $display("** FAIL **");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32, 22, 2, 1; one step per returned bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Read one word through the priority port and check it one cycle later.
  task automatic read_check(input addr_t a);
    @(posedge clk_i);
    rd_req_i  <= 1'b1;
    rd_addr_i <= a;
    @(posedge clk_i);
    rd_req_i  <= 1'b0;
    @(negedge clk_i);
    compare("rd_data_o", rd_data_o, model[a % MEM_DEPTH]);
  endtask

  task automatic run_job(input addr_t b, input addr_t s, input len_t n, input bit clearing);
    int    beats;
    int    stall_left;
    logic  finished;
    addr_t a;
    beats      = 0;
    stall_left = 0;
    finished   = 1'b0;
    @(posedge clk_i);
    start_i  <= 1'b1;
    base_i   <= b;
    stride_i <= s;
    len_i    <= n;
    @(posedge clk_i);
    compare("ready_start_o", ready_start_o, 1'b1);  // Start is taken on this edge.
    start_i <= 1'b0;
    while (!finished) begin
      @(posedge clk_i);
      if (valid_i && ready_o) begin
        a = b + s * addr_t'(beats);  // Beat k lands at base plus k times stride.
        for (int i = 0; i < 4; i++) begin
          if (strb_i[i]) model[a % MEM_DEPTH][i*8 +: 8] = data_i[i*8 +: 8];
        end
        beats++;
      end
      if (done_o) begin
        compare("ready_start_o", ready_start_o, 1'b1);
        finished = 1'b1;
      end
      if (valid_i && !ready_o) begin
        valid_i <= 1'b1;  // Hold the stalled beat.
      end else if (beats < n && !finished && (clearing || rand_bits(2) != 0)) begin
        valid_i <= 1'b1;
        data_i  <= clearing ? '0 : rand_bits(32);
        strb_i  <= clearing ? 4'hf : strb_t'(rand_bits(4));
      end else begin
        valid_i <= 1'b0;
      end
      // Read-port stalls come in random stretches.
      if (clearing || finished) begin
        rd_req_i <= 1'b0;
      end else if (stall_left > 0 || rand_bits(3) == 0) begin
        stall_left = (stall_left > 0) ? stall_left - 1 : rand_bits(3);
        rd_req_i  <= 1'b1;
        rd_addr_i <= rand_bits(16);
      end else begin
        rd_req_i <= 1'b0;
      end
    end
    compare("beats accepted", beats, n);
    @(posedge clk_i);
    compare("done_o", done_o, 1'b0);
    for (int k = 0; k < n; k++) begin
      read_check(b + s * addr_t'(k));
    end
    read_check(rand_bits(16));
  endtask

  initial begin
    addr_t      b;
    addr_t      s;
    len_t       n;
    logic [1:0] mode;
    lfsr      = 32'h2bcd_c373;
    rst_ni    = 1'b0;
    start_i   = 1'b0;
    base_i    = '0;
    stride_i  = '0;
    len_i     = '0;
    data_i    = '0;
    strb_i    = '0;
    valid_i   = 1'b0;
    rd_req_i  = 1'b0;
    rd_addr_i = '0;
    for (int i = 0; i < MEM_DEPTH; i++) model[i] = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    compare("ready_start_o", ready_start_o, 1'b1);
    compare("ready_o", ready_o, 1'b0);
    compare("done_o", done_o, 1'b0);
    compare("rd_data_o", rd_data_o, '0);
    // Zero the whole scratchpad so that it matches the model.
    run_job('0, addr_t'(1), len_t'(MEM_DEPTH), 1'b1);
    for (int j = 0; j < NUM_JOBS; j++) begin
      mode = rand_bits(2);
      case (mode)
        2'd0:    s = '0;
        2'd1:    s = addr_t'(1);
        2'd2:    s = rand_bits(16);
        default: s = addr_t'(MEM_DEPTH / 4 * (3 + rand_bits(2)));  // Passes the depth.
      endcase
      b = rand_bits(16);
      n = len_t'(1 + rand_bits(4));
      run_job(b, s, n, 1'b0);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: verification/sink_checker.sv
// Handshake and state assertions for the sink controller.
// Bound into every stream_sink instance.

`timescale 1ns/1ns

module sink_checker (
  input logic                  clk_i,
  input logic                  rst_ni,
  input sink_pkg::sink_state_e state_i,
  input logic                  wr_req_i,
  input logic                  done_i,
  input logic                  valid_i,
  input logic                  ready_i,
  input sink_pkg::word_t       data_i,
  input sink_pkg::strb_t       strb_i
);

  import sink_pkg::*;

  // No write may leave the controller between jobs.
  no_req_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == SINK_IDLE) |-> !wr_req_i)
    else $error("Write request raised while the controller is idle.");

  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else $error("Done pulse lasted longer than one cycle.");

  // A stalled beat keeps its payload until it is taken.
  stream_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && !ready_i) |=> (valid_i && $stable(data_i) && $stable(strb_i)))
    else $error("Stream beat changed while valid was high and ready was low.");

endmodule

bind stream_sink sink_checker i_checker (
  .clk_i   ( clk_i    ),
  .rst_ni  ( rst_ni   ),
  .state_i ( state_q  ),
  .wr_req_i( wr_req_o ),
  .done_i  ( done_o   ),
  .valid_i ( valid_i  ),
  .ready_i ( ready_o  ),
  .data_i  ( data_i   ),
  .strb_i  ( strb_i   )
);

// File: logic/sink_subsystem.sv
// Top level of the streaming write engine.
// Connects the sink controller, address generator, address FIFO
// and the scratchpad with its outside read port.

`timescale 1ns/1ns

module sink_subsystem #(
  parameter int unsigned MEM_DEPTH  = 1024,
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  sink_pkg::addr_t base_i,
  input  sink_pkg::addr_t stride_i,
  input  sink_pkg::len_t  len_i,
  output logic            ready_start_o,
  output logic            done_o,
  input  sink_pkg::word_t data_i,
  input  sink_pkg::strb_t strb_i,
  input  logic            valid_i,
  output logic            ready_o,
  input  logic            rd_req_i,
  input  sink_pkg::addr_t rd_addr_i,
  output sink_pkg::word_t rd_data_o
);

  import sink_pkg::*;

  addr_t gen_addr;
  logic  gen_valid, gen_ready;
  logic  gen_en, gen_clr, gen_done;
  addr_t fifo_addr;
  logic  fifo_valid, fifo_ready, fifo_empty;
  logic  wr_req, wr_gnt;
  addr_t wr_addr;
  word_t wr_data;
  strb_t wr_strb;

  stream_sink i_sink (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .start_i       ( start_i       ),
    .base_i        ( base_i        ),
    .stride_i      ( stride_i      ),
    .len_i         ( len_i         ),
    .ready_start_o ( ready_start_o ),
    .done_o        ( done_o        ),
    .data_i        ( data_i        ),
    .strb_i        ( strb_i        ),
    .valid_i       ( valid_i       ),
    .ready_o       ( ready_o       ),
    .wr_req_o      ( wr_req        ),
    .wr_addr_o     ( wr_addr       ),
    .wr_data_o     ( wr_data       ),
    .wr_strb_o     ( wr_strb       ),
    .wr_gnt_i      ( wr_gnt        ),
    .gen_en_o      ( gen_en        ),
    .gen_clr_o     ( gen_clr       ),
    .gen_done_i    ( gen_done      ),
    .fifo_addr_i   ( fifo_addr     ),
    .fifo_valid_i  ( fifo_valid    ),
    .fifo_ready_o  ( fifo_ready    ),
    .fifo_empty_i  ( fifo_empty    )
  );

  sink_addr_gen i_addr_gen (
    .clk_i        ( clk_i     ),
    .rst_ni       ( rst_ni    ),
    .en_i         ( gen_en    ),
    .clr_i        ( gen_clr   ),
    .base_i       ( base_i    ),
    .stride_i     ( stride_i  ),
    .len_i        ( len_i     ),
    .addr_o       ( gen_addr  ),
    .addr_valid_o ( gen_valid ),
    .addr_ready_i ( gen_ready ),
    .done_o       ( gen_done  )
  );

  // The FIFO is flushed together with the generator at job end.
  sink_addr_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clr_i        ( gen_clr    ),
    .push_data_i  ( gen_addr   ),
    .push_valid_i ( gen_valid  ),
    .push_ready_o ( gen_ready  ),
    .pop_data_o   ( fifo_addr  ),
    .pop_valid_o  ( fifo_valid ),
    .pop_ready_i  ( fifo_ready ),
    .empty_o      ( fifo_empty )
  );

  scratch_mem #(
    .MEM_DEPTH ( MEM_DEPTH )
  ) i_mem (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .wr_req_i  ( wr_req    ),
    .wr_addr_i ( wr_addr   ),
    .wr_data_i ( wr_data   ),
    .wr_strb_i ( wr_strb   ),
    .wr_gnt_o  ( wr_gnt    ),
    .rd_req_i  ( rd_req_i  ),
    .rd_addr_i ( rd_addr_i ),
    .rd_data_o ( rd_data_o )
  );

endmodule

// File: logic/scratch_mem.sv
// Word-addressed scratchpad with per-byte write enables.
// One granted write port and one read port that has priority over it;
// read data is registered.

`timescale 1ns/1ns

module scratch_mem #(
  parameter int unsigned MEM_DEPTH = 1024
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            wr_req_i,
  input  sink_pkg::addr_t wr_addr_i,
  input  sink_pkg::word_t wr_data_i,
  input  sink_pkg::strb_t wr_strb_i,
  output logic            wr_gnt_o,
  input  logic            rd_req_i,
  input  sink_pkg::addr_t rd_addr_i,
  output sink_pkg::word_t rd_data_o
);

  import sink_pkg::*;

  localparam int unsigned IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  word_t             mem_q [MEM_DEPTH];
  word_t             rd_data_q;
  logic  [IDX_W-1:0] wr_idx;
  logic  [IDX_W-1:0] rd_idx;

  // Addresses fold onto the physical depth.
  assign wr_idx = IDX_W'(wr_addr_i % MEM_DEPTH);
  assign rd_idx = IDX_W'(rd_addr_i % MEM_DEPTH);

  assign wr_gnt_o  = ~rd_req_i;  // A read blocks the write in its cycle.
  assign rd_data_o = rd_data_q;

  always_ff @(posedge clk_i) begin
    if (wr_req_i && wr_gnt_o) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_strb_i[b]) begin
          mem_q[wr_idx][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

  // Read data is captured only on a read request.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_q <= '0;
    end else if (rd_req_i) begin
      rd_data_q <= mem_q[rd_idx];
    end
  end

endmodule

// File: logic/stream_sink.sv
// Sink controller.
// Job state machine, pairing of stream beats with generated addresses
// into scratchpad write requests, and the registered done pulse.

`timescale 1ns/1ns

module stream_sink (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Job control.
  input  logic            start_i,
  input  sink_pkg::addr_t base_i,
  input  sink_pkg::addr_t stride_i,
  input  sink_pkg::len_t  len_i,
  output logic            ready_start_o,
  output logic            done_o,
  // Incoming stream.
  input  sink_pkg::word_t data_i,
  input  sink_pkg::strb_t strb_i,
  input  logic            valid_i,
  output logic            ready_o,
  // Scratchpad write port.
  output logic            wr_req_o,
  output sink_pkg::addr_t wr_addr_o,
  output sink_pkg::word_t wr_data_o,
  output sink_pkg::strb_t wr_strb_o,
  input  logic            wr_gnt_i,
  // Address generator.
  output logic            gen_en_o,
  output logic            gen_clr_o,
  input  logic            gen_done_i,
  // Address FIFO.
  input  sink_pkg::addr_t fifo_addr_i,
  input  logic            fifo_valid_i,
  output logic            fifo_ready_o,
  input  logic            fifo_empty_i
);

  import sink_pkg::*;

  sink_state_e state_q, state_d;
  logic        done_q, done_d;
  logic        active;
  logic        wr_fire;

  assign active = (state_q != SINK_IDLE);

  // A write needs both a beat and its address.
  assign wr_req_o  = active & valid_i & fifo_valid_i;
  assign wr_addr_o = active ? fifo_addr_i : '0;
  assign wr_data_o = active ? data_i : '0;
  assign wr_strb_o = active ? strb_i : '0;
  assign wr_fire   = wr_req_o & wr_gnt_i;

  assign ready_o       = active & (~valid_i | wr_fire);
  assign fifo_ready_o  = wr_fire;  // Address leaves with its beat.
  assign ready_start_o = (state_q == SINK_IDLE);
  assign done_o        = done_q;

  always_comb begin
    state_d   = state_q;
    done_d    = 1'b0;
    gen_en_o  = 1'b0;
    gen_clr_o = 1'b0;
    case (state_q)
      SINK_IDLE: begin
        if (start_i) begin
          state_d  = SINK_WORKING;
          gen_en_o = 1'b1;  // Generator captures the job fields now.
        end
      end
      SINK_WORKING: begin
        gen_en_o = 1'b1;
        if (gen_done_i) begin
          state_d = SINK_DRAIN;
        end
      end
      SINK_DRAIN: begin
        gen_en_o = 1'b1;
        // Wait for the last queued address to be written.
        if (fifo_empty_i) begin
          state_d   = SINK_IDLE;
          gen_en_o  = 1'b0;
          gen_clr_o = 1'b1;
          done_d    = 1'b1;
        end
      end
      default: begin
        state_d   = SINK_IDLE;
        gen_clr_o = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SINK_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;  // One-cycle pulse in the first idle cycle.
    end
  end

endmodule

// File: logic/sink_addr_fifo.sv
// First-word-fall-through address FIFO between the generator and
// the write path, built as a circular buffer with an occupancy count.

`timescale 1ns/1ns

module sink_addr_fifo #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clr_i,
  input  sink_pkg::addr_t push_data_i,
  input  logic            push_valid_i,
  output logic            push_ready_o,
  output sink_pkg::addr_t pop_data_o,
  output logic            pop_valid_o,
  input  logic            pop_ready_i,
  output logic            empty_o
);

  import sink_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  addr_t             buf_q [FIFO_DEPTH];
  logic  [PTR_W-1:0] wr_ptr_q;
  logic  [PTR_W-1:0] rd_ptr_q;
  logic  [CNT_W-1:0] count_q;
  logic              push;
  logic              pop;

  assign push_ready_o = (count_q != CNT_W'(FIFO_DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign empty_o      = (count_q == '0);
  assign pop_data_o   = buf_q[rd_ptr_q];  // Oldest entry falls through.

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // A pushed address is written at the write pointer.
  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// File: logic/sink_addr_gen.sv
// Strided word-address generator.
// Loads base, stride and length on the first enabled cycle after a clear,
// then issues one address per accepted handshake and raises done_o
// once the final address has been taken.

`timescale 1ns/1ns

module sink_addr_gen (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_i,
  input  logic            clr_i,
  input  sink_pkg::addr_t base_i,
  input  sink_pkg::addr_t stride_i,
  input  sink_pkg::len_t  len_i,
  output sink_pkg::addr_t addr_o,
  output logic            addr_valid_o,
  input  logic            addr_ready_i,
  output logic            done_o
);

  import sink_pkg::*;

  addr_t cur_addr_q;   // Address offered in the current cycle.
  addr_t stride_q;
  len_t  remaining_q;  // Words still to be issued.
  logic  loaded_q;     // Job fields have been captured.
  logic  done_q;
  logic  addr_fire;

  assign addr_valid_o = en_i & loaded_q & (remaining_q != '0);
  assign addr_fire    = addr_valid_o & addr_ready_i;
  assign addr_o       = cur_addr_q;
  assign done_o       = done_q;

  // The address register wraps naturally modulo 2^16.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cur_addr_q  <= '0;
      stride_q    <= '0;
      remaining_q <= '0;
      loaded_q    <= 1'b0;
      done_q      <= 1'b0;
    end else if (clr_i) begin
      remaining_q <= '0;
      loaded_q    <= 1'b0;
      done_q      <= 1'b0;
    end else if (en_i && !loaded_q) begin
      cur_addr_q  <= base_i;  // Capture the job on the start cycle.
      stride_q    <= stride_i;
      remaining_q <= len_i;
      loaded_q    <= 1'b1;
    end else if (addr_fire) begin
      cur_addr_q  <= cur_addr_q + stride_q;
      remaining_q <= remaining_q - len_t'(1);
      if (remaining_q == len_t'(1)) begin
        done_q <= 1'b1;  // Last address has just been accepted.
      end
    end
  end

endmodule

// File: logic/sink_pkg.sv
// Shared types of the streaming write engine.
// Data word, byte strobe, word address and job length types,
// and the state encoding of the sink controller.

package sink_pkg;

  // One data word of the stream and of the scratchpad.
  typedef logic [31:0] word_t;

  // Byte-enable mask of one word.
  typedef logic [3:0] strb_t;

  // Word address into the scratchpad.
  typedef logic [15:0] addr_t;

  // Job length in words.
  typedef logic [15:0] len_t;

  // Job states of the sink controller.
  typedef enum logic [1:0] {
    SINK_IDLE    = 2'd0,
    SINK_WORKING = 2'd1,
    SINK_DRAIN   = 2'd2
  } sink_state_e;

endpackage
